// File: Makefile
TOP := tbFbsbDecoder

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): verilog.f $(shell cat verilog.f)
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Verification failed" sim.log || ! grep -q "Verification passed" sim.log; then \
		echo "simulation failed, see sim.log"; exit 1; \
	fi

lint:
	verilator --lint-only -Wall --top-module fbsbDecoder \
		hdl/fbsbPkg.sv hdl/bitSampler.sv hdl/frameSequencer.sv hdl/fbsbDecoder.sv

clean:
	rm -rf obj_dir sim.log

// File: hdl/bitSampler.sv
`timescale 1ns/1ps

module bitSampler (
    input  logic                pclk,
    input  logic                resetn,
    input  logic                rx,
    input  logic                align,
    output logic                lineLevel,
    output fbsbPkg::bitResult_t sampledBit
);

    logic [1:0] rxSync;

    fbsbPkg::bitCount_t bitCnt;
    fbsbPkg::bitCount_t nextSample;

    logic samplePoint;
    logic lastCount;

    logic [fbsbPkg::samplesPerBit-1:0] capture;

    ////////////////////
    // synchronizer

    // two flops against metastability on the raw line
    always_ff @(posedge pclk or negedge resetn) begin
        if (!resetn) begin
            rxSync <= 2'b00;
        end else begin
            rxSync <= {rxSync[0], rx};
        end
    end

    assign lineLevel = rxSync[1];

    ////////////////////
    // bit timing

    assign lastCount = (bitCnt == fbsbPkg::cyclesPerBit - 1'b1);
    assign samplePoint = (bitCnt == nextSample);

    // align wins over the wrap
    always_ff @(posedge pclk or negedge resetn) begin
        if (!resetn) begin
            bitCnt     <= '0;
            nextSample <= fbsbPkg::firstSampleOffset;
        end else if (align || lastCount) begin
            bitCnt     <= '0;
            nextSample <= fbsbPkg::firstSampleOffset;
        end else begin
            bitCnt <= bitCnt + 1'b1;
            // step to the next sample slot
            if (samplePoint) begin
                nextSample <= nextSample + fbsbPkg::sampleSpacing;
            end
        end
    end

    ////////////////////
    // sample capture

    // oldest sample shifts out the top
    always_ff @(posedge pclk) begin
        if (samplePoint) begin
            capture <= {capture[fbsbPkg::samplesPerBit-2:0], lineLevel};
        end
    end

    // last sample sits at 45, so the word is complete by count 49
    assign sampledBit.done  = lastCount;
    assign sampledBit.level = fbsbPkg::majorityVote(capture);

    ////////////////////
    // checks

    counterInRange : assert property (
        @(posedge pclk) disable iff (!resetn)
        bitCnt <= fbsbPkg::cyclesPerBit - 1'b1
    ) else $error("bit counter out of range");

    // a restarted bit must run its full length
    noDoneAfterAlign : assert property (
        @(posedge pclk) disable iff (!resetn)
        align |=> !sampledBit.done
    ) else $error("bit done right after align");

endmodule

// File: hdl/fbsbDecoder.sv
`timescale 1ns/1ps

module fbsbDecoder (
    input  logic       pclk,
    input  logic       resetn,
    input  logic       rx,
    output logic [7:0] data,
    output logic       dataValid,
    output logic       trigOut
);

    // synchronized line for edge detection
    logic lineLevel;

    // vote and end of each bit time
    fbsbPkg::bitResult_t sampledBit;

    // sequencer restarts the bit grid
    logic align;

    ////////////////////
    // sampling

    bitSampler i_bitSampler (
        .pclk       (pclk),
        .resetn     (resetn),
        .rx         (rx),
        .align      (align),
        .lineLevel  (lineLevel),
        .sampledBit (sampledBit)
    );

    ////////////////////
    // framing

    frameSequencer i_frameSequencer (
        .pclk       (pclk),
        .resetn     (resetn),
        .lineLevel  (lineLevel),
        .sampledBit (sampledBit),
        .align      (align),
        .data       (data),
        .dataValid  (dataValid),
        .trigOut    (trigOut)
    );

endmodule

// File: hdl/fbsbPkg.sv
package fbsbPkg;

    ////////////////////
    // line timing

    // pclk cycles in one bit time
    localparam logic [5:0] cyclesPerBit = 6'd50;

    // counter range 0 to cyclesPerBit-1
    typedef logic [$clog2(cyclesPerBit)-1:0] bitCount_t;

    // votes per bit
    localparam int samplesPerBit = 5;

    // first sample lands a little after the bit edge
    localparam bitCount_t firstSampleOffset = 6'd5;

    // so samples fall at 5, 15, 25, 35 and 45
    localparam bitCount_t sampleSpacing = 6'd10;

    ////////////////////
    // frame layout

    // bit times in each preamble
    localparam int preambleBits = 5;

    // payload bits, msb first
    localparam int dataBits = 8;

    ////////////////////
    // shared types

    // result of one bit time
    typedef struct packed {
        logic done;
        logic level;
    } bitResult_t;

    typedef enum logic [2:0] {
        idle,
        preambleHigh,
        pending,
        preambleLow,
        dataBit
    } frameState_t;

    // majority of the samples, an odd count never ties
    function automatic logic majorityVote(input logic [samplesPerBit-1:0] samples);
        int unsigned ones;
        ones = 0;
        for (int i = 0; i < samplesPerBit; i++) begin
            ones += samples[i];
        end
        return ones > (samplesPerBit / 2);
    endfunction

endpackage

// File: hdl/frameSequencer.sv
`timescale 1ns/1ps

module frameSequencer (
    input  logic                pclk,
    input  logic                resetn,
    input  logic                lineLevel,
    input  fbsbPkg::bitResult_t sampledBit,
    output logic                align,
    output logic [7:0]          data,
    output logic                dataValid,
    output logic                trigOut
);

    fbsbPkg::frameState_t state;

    // counts preamble bits, then data bits
    logic [2:0] bitIdx;

    logic [6:0] shiftReg;
    logic [7:0] nextByte;

    logic startSeen;
    logic edgeSeen;
    logic lastPreamble;
    logic lastData;

    ////////////////////
    // realignment

    // rising line in idle starts the high preamble
    assign startSeen = (state == fbsbPkg::idle) && lineLevel;

    // falling edge after the stretch sets the bit grid for the rest
    assign edgeSeen = (state == fbsbPkg::pending) && !lineLevel;

    assign align = startSeen || edgeSeen;

    ////////////////////
    // bit bookkeeping

    assign lastPreamble = (bitIdx == 3'(fbsbPkg::preambleBits - 1));
    assign lastData     = (bitIdx == 3'(fbsbPkg::dataBits - 1));

    // line low means 1
    assign nextByte = {shiftReg, ~sampledBit.level};

    always_ff @(posedge pclk) begin
        if ((state == fbsbPkg::dataBit) && sampledBit.done) begin
            shiftReg <= nextByte[6:0];
        end
    end

    ////////////////////
    // frame FSM

    always_ff @(posedge pclk or negedge resetn) begin
        if (!resetn) begin
            state     <= fbsbPkg::idle;
            bitIdx    <= '0;
            data      <= '0;
            dataValid <= 1'b0;
            trigOut   <= 1'b0;
        end else begin
            dataValid <= 1'b0;

            case (state)
                fbsbPkg::idle: begin
                    if (startSeen) begin
                        state  <= fbsbPkg::preambleHigh;
                        bitIdx <= '0;
                    end
                end

                fbsbPkg::preambleHigh: begin
                    if (sampledBit.done) begin
                        // a low vote here means no valid frame
                        if (!sampledBit.level) begin
                            state <= fbsbPkg::idle;
                        end else if (lastPreamble) begin
                            state  <= fbsbPkg::pending;
                            bitIdx <= '0;
                        end else begin
                            bitIdx <= bitIdx + 1'b1;
                        end
                    end
                end

                // wait out a stretch of any length for the edge
                fbsbPkg::pending: begin
                    if (edgeSeen) begin
                        state  <= fbsbPkg::preambleLow;
                        bitIdx <= '0;
                    end
                end

                fbsbPkg::preambleLow: begin
                    if (sampledBit.done) begin
                        if (sampledBit.level) begin
                            state <= fbsbPkg::idle;
                        end else if (lastPreamble) begin
                            state  <= fbsbPkg::dataBit;
                            bitIdx <= '0;
                        end else begin
                            bitIdx <= bitIdx + 1'b1;
                        end
                    end
                end

                fbsbPkg::dataBit: begin
                    if (sampledBit.done) begin
                        if (lastData) begin
                            // byte, strobe and toggle all land on the same edge
                            data      <= nextByte;
                            dataValid <= 1'b1;
                            trigOut   <= ~trigOut;
                            state     <= fbsbPkg::idle;
                        end else begin
                            bitIdx <= bitIdx + 1'b1;
                        end
                    end
                end

                default: begin
                    state <= fbsbPkg::idle;
                end
            endcase
        end
    end

    ////////////////////
    // checks

    validIsPulse : assert property (
        @(posedge pclk) disable iff (!resetn)
        dataValid |=> !dataValid
    ) else $error("dataValid held for two cycles");

    // trigger follows accepted frames only
    trigWithValid : assert property (
        @(posedge pclk) disable iff (!resetn)
        $changed(trigOut) |-> dataValid
    ) else $error("trigOut changed without dataValid");

endmodule

// File: verif/tbFbsbDecoder.sv
`timescale 1ns/1ps

module tbFbsbDecoder;

    logic       pclk = 1'b0;
    logic       resetn;
    logic       rx;
    logic [7:0] data;
    logic       dataValid;
    logic       trigOut;

    // bytes sent on the line, oldest first
    logic [7:0] expectQ[$];

    int mismatchCount = 0;
    int failCount = 0;
    int sentFrames = 0;
    int acceptedFrames = 0;
    int validCount = 0;
    int toggleCount = 0;

    logic lastTrig = 1'b0;

    fbsbDecoder i_dut (
        .pclk      (pclk),
        .resetn    (resetn),
        .rx        (rx),
        .data      (data),
        .dataValid (dataValid),
        .trigOut   (trigOut)
    );

    // 20 ns period
    always #10 pclk = ~pclk;

    ////////////////////
    // reference model

    function automatic logic majorityOfFive(input logic [4:0] samples);
        int ones;
        ones = 0;
        for (int i = 0; i < 5; i++) begin
            if (samples[i]) begin
                ones++;
            end
        end
        return (ones >= 3);
    endfunction

    // line levels in, decoded byte out
    function automatic logic [7:0] expectedByte(input logic [7:0] lineLevels);
        logic [7:0] result;
        logic [4:0] copies;
        result = '0;
        for (int i = 0; i < 8; i++) begin
            copies = {5{lineLevels[i]}};
            // a low line carries a 1
            result[i] = ~majorityOfFive(copies);
        end
        return result;
    endfunction

    ////////////////////
    // checks

    task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("error at time %0t: %s is 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            mismatchCount++;
        end
    endtask

    task automatic checkResetState(input string when);
        checkEqual(32'(dataValid), 32'(1'b0), {"dataValid ", when});
        checkEqual(32'(trigOut), 32'(1'b0), {"trigOut ", when});
        checkEqual(32'(data), 32'(8'h00), {"data ", when});
        checkEqual(32'(i_dut.i_frameSequencer.state), 32'(fbsbPkg::idle),
                   {"sequencer state ", when});
    endtask

    // polls at the falling edge, gives up after the given cycles
    task automatic waitForValid(input int cycles, output bit seen);
        int waited;
        seen = 1'b0;
        waited = 0;
        while (!seen && waited < cycles) begin
            if (dataValid) begin
                seen = 1'b1;
            end else begin
                @(negedge pclk);
                waited++;
            end
        end
    endtask

    task automatic expectNoValid(input int cycles);
        int waited;
        bit seen;
        waited = 0;
        seen = 1'b0;
        while (!seen && waited < cycles) begin
            @(negedge pclk);
            waited++;
            if (dataValid) begin
                seen = 1'b1;
            end
        end
        if (seen) begin
            $display("dataValid arrived at time %0t for a frame with a short preamble",
                     $time);
            failCount++;
        end
    endtask

    ////////////////////
    // line driver

    task automatic driveLevel(input logic level, input int cycles);
        repeat (cycles) begin
            @(posedge pclk);
            rx <= level;
        end
    endtask

    // 8 cycles can never cover two samples spaced 10 apart
    task automatic driveBit(input logic level, input bit withGlitch);
        int glitchStart;
        logic value;
        glitchStart = -100;
        if (withGlitch) begin
            glitchStart = int'($urandom_range(0, int'(fbsbPkg::cyclesPerBit) - 8));
        end
        for (int j = 0; j < int'(fbsbPkg::cyclesPerBit); j++) begin
            value = level;
            if (j >= glitchStart && j < glitchStart + 8) begin
                value = ~level;
            end
            @(posedge pclk);
            rx <= value;
        end
    endtask

    task automatic sendFrame(input logic [7:0] value, input bit withGlitch);
        logic [7:0] lineBits;
        int stretch;
        lineBits = ~value;
        stretch = int'($urandom_range(0, 40));
        expectQ.push_back(expectedByte(lineBits));
        sentFrames++;
        // high preamble plus a stretch of random length
        driveLevel(1'b1, fbsbPkg::preambleBits * int'(fbsbPkg::cyclesPerBit) + stretch);
        driveLevel(1'b0, fbsbPkg::preambleBits * int'(fbsbPkg::cyclesPerBit));
        for (int i = fbsbPkg::dataBits - 1; i >= 0; i--) begin
            driveBit(lineBits[i], withGlitch);
        end
        driveLevel(1'b0, 100);
    endtask

    ////////////////////
    // monitor and checker

    always @(negedge pclk) begin
        if (resetn) begin
            if (dataValid) begin
                validCount++;
            end
            if (trigOut !== lastTrig) begin
                toggleCount++;
            end
            lastTrig = trigOut;
        end
    end

    initial begin : compareProc
        logic [7:0] expected;
        bit seen;
        forever begin
            @(negedge pclk);
            if (expectQ.size() > 0) begin
                // a frame takes under 1000 cycles
                waitForValid(2000, seen);
                expected = expectQ.pop_front();
                if (seen) begin
                    checkEqual(32'(data), 32'(expected), "received byte");
                    acceptedFrames++;
                    checkEqual(32'(trigOut), 32'(acceptedFrames % 2), "trigOut parity");
                end else begin
                    $display("no dataValid arrived for byte 0x%02h by time %0t",
                             expected, $time);
                    failCount++;
                end
            end
        end
    end

    ////////////////////
    // scenarios

    initial begin : stimulus
        logic [7:0] value;
        logic       trigBefore;
        int         validBefore;
        int         waited;

        rx = 1'b0;
        resetn = 1'b0;
        void'($urandom(6308));

        repeat (5) begin
            @(negedge pclk);
            checkResetState("during reset");
        end
        @(posedge pclk);
        resetn <= 1'b1;
        @(negedge pclk);
        checkResetState("after reset");

        // corner bytes first
        sendFrame(8'h00, 1'b0);
        sendFrame(8'hff, 1'b0);

        for (int n = 0; n < 20; n++) begin
            value = 8'($urandom_range(0, 255));
            sendFrame(value, 1'b0);
        end

        // one short glitch in every data bit
        for (int n = 0; n < 8; n++) begin
            value = 8'($urandom_range(0, 255));
            sendFrame(value, 1'b1);
        end

        // high preamble of two bit times only
        validBefore = validCount;
        trigBefore = trigOut;
        driveLevel(1'b1, 2 * int'(fbsbPkg::cyclesPerBit));
        driveLevel(1'b0, 400);
        expectNoValid(2000);
        checkEqual(32'(validCount), 32'(validBefore), "pulses after rejected frame");
        checkEqual(32'(trigOut), 32'(trigBefore), "trigOut after rejected frame");
        checkEqual(32'(i_dut.i_frameSequencer.state), 32'(fbsbPkg::idle),
                   "sequencer state after rejected frame");

        // decoder has to recover
        value = 8'($urandom_range(0, 255));
        sendFrame(value, 1'b0);

        waited = 0;
        while (expectQ.size() > 0 && waited < 3000) begin
            @(negedge pclk);
            waited++;
        end
        if (expectQ.size() > 0) begin
            $display("%0d expected bytes never got a dataValid", expectQ.size());
            failCount++;
        end

        checkEqual(32'(validCount), 32'(sentFrames), "dataValid pulse count");
        checkEqual(32'(toggleCount), 32'(sentFrames), "trigOut toggle count");
        checkEqual(32'(acceptedFrames), 32'(sentFrames), "accepted frame count");
        checkEqual(32'(trigOut), 32'(sentFrames % 2), "final trigOut");

        $display("frames %0d, mismatches %0d, other failures %0d",
                 sentFrames, mismatchCount, failCount);
        if (mismatchCount == 0 && failCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
hdl/fbsbPkg.sv
hdl/bitSampler.sv
hdl/frameSequencer.sv
hdl/fbsbDecoder.sv
verif/tbFbsbDecoder.sv
